//--- rtl/simd_pkg.sv
/*
  Shared constants and types for the SIMD result wrapper.
  Lane and tag widths, queue sizes, the option entry layout and the
  opcode and sequencer state encodings all live here. Modules pull in
  what they need with a wildcard import in their header.
*/

package simd_pkg;

  // ------------------------------
  // Datapath sizes
  // ------------------------------
  localparam int NUM_LANES  = 4;
  localparam int LANE_W     = 16;
  localparam int CNTL_W     = 2;
  localparam int TAG_W      = 8;
  localparam int OPT_PTR_W  = 4;
  localparam int OPT_DEPTH  = 1 << OPT_PTR_W;
  localparam int LANE_CNT_W = 3;

  // ------------------------------
  // Queue sizing
  // ------------------------------
  // Thresholds leave room for words already in flight
  localparam int LANE_FIFO_DEPTH  = 8;
  localparam int LANE_FIFO_THRESH = 6;
  localparam int TAG_FIFO_DEPTH   = 4;
  localparam int TAG_FIFO_THRESH  = 3;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MAX = 2'd2,
    OP_XOR = 2'd3
  } simd_op_e;

  // Upstream sequencer states
  typedef enum logic [2:0] {
    S_WAIT         = 3'd0,
    S_CHECK        = 3'd1,
    S_WAIT_SIMD    = 3'd2,
    S_SEND         = 3'd3,
    S_WAIT_CPL     = 3'd4,
    S_WAIT_CPL_LOW = 3'd5,
    S_DONE         = 3'd6
  } seq_state_e;

  // ------------------------------
  // Payload types
  // ------------------------------
  // One lane result with its start/end marker
  typedef struct packed {
    logic [CNTL_W-1:0] cntl;
    logic [LANE_W-1:0] data;
  } lane_word_t;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [OPT_PTR_W-1:0]  opt_ptr;
    logic [LANE_CNT_W-1:0] num_lanes;
  } tag_info_t;

  // Entry of the option memory
  typedef struct packed {
    logic     enable;
    simd_op_e op;
  } option_t;

  typedef lane_word_t [NUM_LANES-1:0] lane_vec_t;

endpackage

//--- rtl/simd_fifo.sv
/*
  Synchronous FIFO with a look-ahead head and an almost-full flag.
  The head entry is visible on pipe_data whenever pipe_valid is high;
  pipe_read drops it. almost_full rises once THRESH entries are held,
  so a writer that stops on it still has room for words in flight.
*/

module simd_fifo #(
  parameter int DEPTH  = 8,
  parameter int THRESH = 6,
  parameter int W      = 18
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         write,
  input  logic [W-1:0] write_data,
  input  logic         pipe_read,
  output logic         pipe_valid,
  output logic [W-1:0] pipe_data,
  output logic         almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [W-1:0]     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Storage
  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_data;
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pipe_read)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous read and write keeps the count
      if (write && !pipe_read)
        count <= count + 1'b1;
      else if (!write && pipe_read)
        count <= count - 1'b1;
    end
  end

  assign pipe_valid  = (count != '0);
  assign pipe_data   = mem[rd_ptr];
  assign almost_full = (count >= CNT_W'(THRESH));

  // ------------------------------
  // Checks
  // ------------------------------
  // Writer must have stopped on almost_full well before this
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(write && !pipe_read && (count == CNT_W'(DEPTH))));

  // Reader pops only what it has seen on pipe_valid
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    pipe_read |-> pipe_valid);

endmodule

//--- rtl/simd_option_mem.sv
/*
  Option memory, one entry per option pointer.
  Each entry holds the SIMD enable bit and opcode. Entries are loaded
  through the write port and read combinationally by the option pointer
  of the tag at the head of the tag queue.
*/

module simd_option_mem
  import simd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 opt_we,
  input  logic [OPT_PTR_W-1:0] opt_addr,
  input  option_t              opt_wdata,
  input  logic [OPT_PTR_W-1:0] rd_addr,
  output option_t              rd_data
);

  option_t entries [OPT_DEPTH];

  // All entries come up disabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < OPT_DEPTH; i++)
        entries[i] <= '0;
    end
    else if (opt_we)
    begin
      entries[opt_addr] <= opt_wdata;
    end
  end

  // Lookup for the head tag
  assign rd_data = entries[rd_addr];

endmodule

//--- rtl/simd_lane_unit.sv
/*
  SIMD lane unit.
  On simd_start every lane's data is combined with the scalar operand
  using the selected opcode and the results are registered. The cntl
  markers pass through. simd_done pulses one cycle after start, and the
  result stays on simd_data until the next start.
*/

module simd_lane_unit
  import simd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              simd_start,
  input  simd_op_e          op,
  input  logic [LANE_W-1:0] scalar,
  input  lane_vec_t         lanes_in,
  output logic              simd_done,
  output lane_vec_t         simd_data
);

  lane_vec_t lane_res;

  // ------------------------------
  // Per-lane operation
  // ------------------------------
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      lane_res[i].cntl = lanes_in[i].cntl;
      case (op)
        // Add and subtract wrap at 16 bits
        OP_ADD: lane_res[i].data = lanes_in[i].data + scalar;
        OP_SUB: lane_res[i].data = lanes_in[i].data - scalar;
        OP_MAX: lane_res[i].data = (lanes_in[i].data > scalar) ? lanes_in[i].data : scalar;
        OP_XOR: lane_res[i].data = lanes_in[i].data ^ scalar;
        default: lane_res[i].data = lanes_in[i].data;
      endcase
    end
  end

  // Result register
  always_ff @(posedge clk)
  begin
    if (simd_start)
      simd_data <= lane_res;
  end

  // Fixed latency of one cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      simd_done <= 1'b0;
    else
      simd_done <= simd_start;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // Sequencer may not restart while a result is still on its way
  a_no_start_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
    simd_start |=> !simd_start);

endmodule

//--- rtl/upstream_seq.sv
/*
  Upstream sequencer.
  Waits for a tag and all masked lane results plus upstream ready, looks
  at the option entry, optionally runs the lane unit, then issues one
  beat and pops the queues. After the beat it waits for the upstream
  complete signal to rise and fall before taking the next tag.
*/

module upstream_seq
  import simd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tag_pending,
  input  logic [NUM_LANES-1:0] lane_pending,
  input  logic [NUM_LANES-1:0] lane_mask,
  input  logic                 up_ready_q,
  input  logic                 up_complete_q,
  input  option_t              opt,
  input  logic                 simd_done,
  input  lane_vec_t            simd_data,
  input  lane_vec_t            lane_heads,
  output logic                 pop_tag,
  output logic [NUM_LANES-1:0] pop_lanes,
  output logic                 simd_start,
  output logic [NUM_LANES-1:0] beat_valid,
  output lane_vec_t            beat_data
);

  seq_state_e state;
  seq_state_e state_next;
  logic       xact_ready;
  logic       send;

  // Unmasked lanes count as present
  assign xact_ready = tag_pending && (&(lane_pending | ~lane_mask));

  // ------------------------------
  // State register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= S_WAIT;
    else
      state <= state_next;
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      S_WAIT:
        if (xact_ready && up_ready_q)
          state_next = S_CHECK;
      // Option entry of the head tag decides the data source
      S_CHECK:
        state_next = opt.enable ? S_WAIT_SIMD : S_SEND;
      S_WAIT_SIMD:
        if (simd_done)
          state_next = S_SEND;
      S_SEND:
        state_next = S_WAIT_CPL;
      S_WAIT_CPL:
        if (up_complete_q)
          state_next = S_WAIT_CPL_LOW;
      S_WAIT_CPL_LOW:
        if (!up_complete_q)
          state_next = S_DONE;
      S_DONE:
        state_next = S_WAIT;
      default:
        state_next = S_WAIT;
    endcase
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign send       = (state == S_SEND);
  assign simd_start = (state == S_CHECK) && opt.enable;

  // Tag and masked lanes leave together with the beat
  assign pop_tag    = send;
  assign pop_lanes  = {NUM_LANES{send}} & lane_mask;
  assign beat_valid = {NUM_LANES{send}} & lane_mask;

  // Lane unit holds its result until the beat goes out
  assign beat_data  = opt.enable ? simd_data : lane_heads;

  // ------------------------------
  // Checks
  // ------------------------------
  a_send_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_SEND) |=> (state != S_SEND));

  // Lane unit answers within its fixed latency
  a_simd_latency : assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_WAIT_SIMD) |-> simd_done);

endmodule

//--- rtl/simd_wrapper.sv
/*
  SIMD result wrapper for one processing element.
  Tags from the controller and per-lane results from the stream engine
  are queued, optionally run through the lane unit as selected by the
  option memory, and sent upstream as one registered beat. Scalar
  registers are registered and passed on to the stream side.
*/

module simd_wrapper
  import simd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [LANE_W-1:0]    rs0,
  input  logic [LANE_W-1:0]    rs1,
  output logic [LANE_W-1:0]    scntl_rs0,
  output logic [LANE_W-1:0]    scntl_rs1,
  input  logic                 tag_valid,
  input  tag_info_t            tag_in,
  output logic                 tag_ready,
  input  logic [NUM_LANES-1:0] res_valid,
  input  lane_vec_t            res_data,
  output logic [NUM_LANES-1:0] res_ready,
  output tag_info_t            up_tag,
  output logic [NUM_LANES-1:0] up_valid,
  output lane_vec_t            up_data,
  input  logic                 up_ready,
  input  logic                 up_complete,
  input  logic                 opt_we,
  input  logic [OPT_PTR_W-1:0] opt_addr,
  input  option_t              opt_wdata
);

  logic                 tag_valid_q;
  tag_info_t            tag_q;
  logic                 up_ready_q;
  logic                 up_complete_q;
  logic                 tag_pending;
  logic                 tag_af;
  tag_info_t            tag_head;
  logic [NUM_LANES-1:0] lane_pending;
  logic [NUM_LANES-1:0] lane_af;
  lane_vec_t            lane_heads;
  logic                 pop_tag;
  logic [NUM_LANES-1:0] pop_lanes;
  option_t              opt;
  logic                 simd_start;
  logic                 simd_done;
  lane_vec_t            simd_data;
  logic [NUM_LANES-1:0] beat_valid;
  lane_vec_t            beat_data;

  // ------------------------------
  // Input registers
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      scntl_rs0     <= '0;
      scntl_rs1     <= '0;
      tag_valid_q   <= 1'b0;
      up_ready_q    <= 1'b0;
      up_complete_q <= 1'b0;
      tag_ready     <= 1'b0;
    end
    else
    begin
      scntl_rs0     <= rs0;
      scntl_rs1     <= rs1;
      tag_valid_q   <= tag_valid;
      up_ready_q    <= up_ready;
      up_complete_q <= up_complete;
      tag_ready     <= ~tag_af;
    end
  end

  always_ff @(posedge clk)
  begin
    tag_q <= tag_in;
  end

  // ------------------------------
  // Queues
  // ------------------------------
  simd_fifo #(
    .DEPTH  (TAG_FIFO_DEPTH),
    .THRESH (TAG_FIFO_THRESH),
    .W      ($bits(tag_info_t))
  ) u_tag_q (
    .clk         (clk),
    .rst_n       (rst_n),
    .write       (tag_valid_q),
    .write_data  (tag_q),
    .pipe_read   (pop_tag),
    .pipe_valid  (tag_pending),
    .pipe_data   (tag_head),
    .almost_full (tag_af)
  );

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane_q
    simd_fifo #(
      .DEPTH  (LANE_FIFO_DEPTH),
      .THRESH (LANE_FIFO_THRESH),
      .W      ($bits(lane_word_t))
    ) u_lane_q (
      .clk         (clk),
      .rst_n       (rst_n),
      .write       (res_valid[i]),
      .write_data  (res_data[i]),
      .pipe_read   (pop_lanes[i]),
      .pipe_valid  (lane_pending[i]),
      .pipe_data   (lane_heads[i]),
      .almost_full (lane_af[i])
    );
  end

  assign res_ready = ~lane_af;

  // ------------------------------
  // Option lookup, lane unit, sequencer
  // ------------------------------
  simd_option_mem u_opt_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .opt_we    (opt_we),
    .opt_addr  (opt_addr),
    .opt_wdata (opt_wdata),
    .rd_addr   (tag_head.opt_ptr),
    .rd_data   (opt)
  );

  simd_lane_unit u_lane_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .simd_start (simd_start),
    .op         (opt.op),
    .scalar     (scntl_rs0),
    .lanes_in   (lane_heads),
    .simd_done  (simd_done),
    .simd_data  (simd_data)
  );

  // Low bits of rs1 select the active lanes
  upstream_seq u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .tag_pending   (tag_pending),
    .lane_pending  (lane_pending),
    .lane_mask     (scntl_rs1[NUM_LANES-1:0]),
    .up_ready_q    (up_ready_q),
    .up_complete_q (up_complete_q),
    .opt           (opt),
    .simd_done     (simd_done),
    .simd_data     (simd_data),
    .lane_heads    (lane_heads),
    .pop_tag       (pop_tag),
    .pop_lanes     (pop_lanes),
    .simd_start    (simd_start),
    .beat_valid    (beat_valid),
    .beat_data     (beat_data)
  );

  // ------------------------------
  // Output beat
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      up_valid <= '0;
    else
      up_valid <= beat_valid;
  end

  // Tag and data hold until the next beat
  always_ff @(posedge clk)
  begin
    if (pop_tag)
    begin
      up_tag  <= tag_head;
      up_data <= beat_data;
    end
  end

endmodule

//--- verif/simd_tb_checks.svh
/*
  Reference model and upstream responder for the wrapper testbench.
  Included inside the testbench module; uses its table and signals.
*/

`ifndef SIMD_TB_CHECKS_SVH
`define SIMD_TB_CHECKS_SVH

function automatic tag_info_t tag_of(input int idx);
  tag_info_t t;
  t.tag       = tbl[idx].tag;
  t.opt_ptr   = tbl[idx].ptr;
  t.num_lanes = LANE_CNT_W'($countones(tbl[idx].mask));
  return t;
endfunction

// Upper bits are filler, low nibble is the lane mask
function automatic logic [LANE_W-1:0] rs1_of(input int idx);
  return {tbl[idx].rs0[15:4] ^ 12'hC3A, tbl[idx].mask};
endfunction

// Expected lane word from the opcode rules
function automatic lane_word_t model_lane(input int idx, input int lane);
  lane_word_t w;
  logic [LANE_W-1:0] s;
  w = tbl[idx].lanes[lane];
  s = tbl[idx].rs0;
  if (tbl[idx].en)
  begin
    case (tbl[idx].op)
      OP_ADD: w.data = LANE_W'(w.data + s);
      OP_SUB: w.data = LANE_W'(w.data - s);
      OP_MAX: w.data = (s > w.data) ? s : w.data;
      default: w.data = w.data ^ s;
    endcase
  end
  return w;
endfunction

task automatic check_beat(input int idx);
  check_count++;
  assert (up_valid == tbl[idx].mask && up_tag == tag_of(idx))
  else
  begin
    $display("ERR %0t: test %0d beat valid %b tag %h, expected %b %h", $time, idx,
             up_valid, up_tag, tbl[idx].mask, tag_of(idx));
    err_count++;
  end
  check_count++;
  assert (scntl_rs0 == tbl[idx].rs0 && scntl_rs1 == rs1_of(idx))
  else
  begin
    $display("ERR %0t: test %0d scalar copies %h %h", $time, idx, scntl_rs0, scntl_rs1);
    err_count++;
  end
  for (int l = 0; l < NUM_LANES; l++)
  begin
    if (tbl[idx].mask[l])
    begin
      check_count++;
      assert (up_data[l] == model_lane(idx, l))
      else
      begin
        $display("ERR %0t: test %0d lane %0d got %h expected %h", $time, idx, l,
                 up_data[l], model_lane(idx, l));
        err_count++;
      end
    end
  end
endtask

// Complete rises two cycles after the beat and falls two cycles later
task automatic answer_complete();
  int c;
  for (c = 0; c < 4; c++)
  begin
    @(posedge clk);
    #2;
    if (c == 1)
      up_complete = 1'b1;
    if (c == 3)
      up_complete = 1'b0;
    @(negedge clk);
    check_count++;
    assert (up_valid == '0)
    else
    begin
      $display("ERR %0t: beat during complete handshake", $time);
      err_count++;
    end
  end
endtask

`endif

//--- verif/simd_wrapper_tb.sv
/*
  Testbench for the SIMD result wrapper.
  A table of tags, options, scalars, lane masks and LCG lane data is
  applied in a loop. Each upstream beat is checked against a reference
  model and answered with a complete handshake.
*/

module simd_wrapper_tb
  import simd_pkg::*;
();

  localparam int          CLK_PERIOD  = 40;
  localparam int          NUM_ENTRIES = 10;
  localparam int          TIMEOUT     = 60 * NUM_ENTRIES + 100;
  localparam logic [31:0] LCG_SEED    = 32'd90;
  localparam logic [31:0] LCG_MUL     = 32'd1664525;
  localparam logic [31:0] LCG_INC     = 32'd1013904223;

  // One table row
  // A batch above one queues that many rows behind a low up_ready
  typedef struct packed {
    logic [TAG_W-1:0]     tag;
    logic [OPT_PTR_W-1:0] ptr;
    logic                 en;
    simd_op_e             op;
    logic [LANE_W-1:0]    rs0;
    logic [NUM_LANES-1:0] mask;
    lane_vec_t            lanes;
    logic [7:0]           hold;
    logic [1:0]           batch;
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  logic [LANE_W-1:0]    rs0;
  logic [LANE_W-1:0]    rs1;
  logic [LANE_W-1:0]    scntl_rs0;
  logic [LANE_W-1:0]    scntl_rs1;
  logic                 tag_valid;
  tag_info_t            tag_in;
  logic                 tag_ready;
  logic [NUM_LANES-1:0] res_valid;
  lane_vec_t            res_data;
  logic [NUM_LANES-1:0] res_ready;
  tag_info_t            up_tag;
  logic [NUM_LANES-1:0] up_valid;
  lane_vec_t            up_data;
  logic                 up_ready;
  logic                 up_complete;
  logic                 opt_we;
  logic [OPT_PTR_W-1:0] opt_addr;
  option_t              opt_wdata;

  entry_t      tbl [NUM_ENTRIES];
  logic [31:0] rng;
  int          n_def;
  int          err_count;
  int          check_count;
  int          test_count;
  int          cycle_count;

  `include "simd_tb_checks.svh"

  simd_wrapper UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .rs0         (rs0),
    .rs1         (rs1),
    .scntl_rs0   (scntl_rs0),
    .scntl_rs1   (scntl_rs1),
    .tag_valid   (tag_valid),
    .tag_in      (tag_in),
    .tag_ready   (tag_ready),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_ready   (res_ready),
    .up_tag      (up_tag),
    .up_valid    (up_valid),
    .up_data     (up_data),
    .up_ready    (up_ready),
    .up_complete (up_complete),
    .opt_we      (opt_we),
    .opt_addr    (opt_addr),
    .opt_wdata   (opt_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: no result after %0d cycles", TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * LCG_MUL + LCG_INC;
  endfunction

  task automatic add_entry(input logic [7:0] tag, input logic [3:0] ptr, input logic en,
                           input simd_op_e op, input logic [15:0] scalar,
                           input logic [3:0] mask, input logic [7:0] hold,
                           input logic [1:0] batch);
    entry_t e;
    e.tag   = tag;
    e.ptr   = ptr;
    e.en    = en;
    e.op    = op;
    e.rs0   = scalar;
    e.mask  = mask;
    e.hold  = hold;
    e.batch = batch;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rng = lcg_next(rng);
      e.lanes[l].cntl = rng[31:30];
      e.lanes[l].data = rng[23:8];
    end
    tbl[n_def] = e;
    n_def++;
  endtask

  task automatic load_option(input int idx);
    @(posedge clk);
    #2;
    opt_we           = 1'b1;
    opt_addr         = tbl[idx].ptr;
    opt_wdata.enable = tbl[idx].en;
    opt_wdata.op     = tbl[idx].op;
    @(posedge clk);
    #2;
    opt_we = 1'b0;
  endtask

  // Tag and masked lane words go in the same cycle
  task automatic push_entry(input int idx);
    do
      @(negedge clk);
    while (!tag_ready || ((res_ready & tbl[idx].mask) != tbl[idx].mask));
    @(posedge clk);
    #2;
    rs0       = tbl[idx].rs0;
    rs1       = rs1_of(idx);
    tag_valid = 1'b1;
    tag_in    = tag_of(idx);
    res_valid = tbl[idx].mask;
    res_data  = tbl[idx].lanes;
    @(posedge clk);
    #2;
    tag_valid = 1'b0;
    res_valid = '0;
  endtask

  task automatic wait_beat();
    do
      @(negedge clk);
    while (up_valid == '0);
  endtask

  task automatic report_test(input int idx, input int err_before);
    test_count++;
    if (err_count == err_before)
      $display("Test %0d tag %02h: ok", idx, tbl[idx].tag);
    else
      $display("Test %0d tag %02h: %0d errors", idx, tbl[idx].tag, err_count - err_before);
  endtask

  initial
  begin
    int i;
    int k;
    int n;
    int err_before;

    rst_n       = 1'b0;
    rs0         = '0;
    rs1         = '0;
    tag_valid   = 1'b0;
    tag_in      = '0;
    res_valid   = '0;
    res_data    = '0;
    up_ready    = 1'b1;
    up_complete = 1'b0;
    opt_we      = 1'b0;
    opt_addr    = '0;
    opt_wdata   = '0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    n_def       = 0;
    rng         = LCG_SEED;

    // tag, ptr, en, op, rs0, mask, hold, batch
    add_entry(8'h11, 4'd0, 1'b0, OP_ADD, 16'h1234, 4'b1111, 8'd0, 2'd1);
    add_entry(8'h22, 4'd1, 1'b1, OP_ADD, 16'hF00D, 4'b1111, 8'd0, 2'd1);
    add_entry(8'h33, 4'd2, 1'b1, OP_SUB, 16'h9001, 4'b1111, 8'd0, 2'd1);
    add_entry(8'h44, 4'd3, 1'b1, OP_MAX, 16'h8000, 4'b1111, 8'd0, 2'd1);
    add_entry(8'h55, 4'd4, 1'b1, OP_XOR, 16'hA5C3, 4'b1111, 8'd0, 2'd1);
    add_entry(8'h66, 4'd5, 1'b0, OP_ADD, 16'h0042, 4'b0101, 8'd0, 2'd1);
    add_entry(8'h77, 4'd6, 1'b1, OP_ADD, 16'h7777, 4'b1010, 8'd0, 2'd1);
    // Queued group shares scalars and mask
    add_entry(8'h88, 4'd7, 1'b0, OP_ADD, 16'h3C3C, 4'b1111, 8'd12, 2'd3);
    add_entry(8'h99, 4'd8, 1'b1, OP_XOR, 16'h3C3C, 4'b1111, 8'd0, 2'd1);
    add_entry(8'hAA, 4'd9, 1'b1, OP_SUB, 16'h3C3C, 4'b1111, 8'd0, 2'd1);

    // ------------------------------
    // Reset
    // ------------------------------
    @(negedge clk);
    check_count++;
    assert (up_valid == '0 && tag_ready == 1'b0)
    else
    begin
      $display("ERR %0t: outputs not cleared in reset", $time);
      err_count++;
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_count++;
    assert (tag_ready == 1'b1 && res_ready == '1 && up_valid == '0)
    else
    begin
      $display("ERR %0t: ready %b/%b after reset", $time, tag_ready, res_ready);
      err_count++;
    end

    // ------------------------------
    // Table loop
    // ------------------------------
    i = 0;
    while (i < NUM_ENTRIES)
    begin
      n = tbl[i].batch;
      if (tbl[i].hold != 0)
      begin
        @(posedge clk);
        #2;
        up_ready = 1'b0;
      end
      for (k = 0; k < n; k++)
        load_option(i + k);
      for (k = 0; k < n; k++)
        push_entry(i + k);
      for (k = 0; k < tbl[i].hold; k++)
      begin
        @(negedge clk);
        check_count++;
        assert (up_valid == '0)
        else
        begin
          $display("ERR %0t: beat while up_ready is low", $time);
          err_count++;
        end
      end
      if (tbl[i].hold != 0)
      begin
        @(posedge clk);
        #2;
        up_ready = 1'b1;
      end
      for (k = 0; k < n; k++)
      begin
        err_before = err_count;
        wait_beat();
        check_beat(i + k);
        answer_complete();
        report_test(i + k, err_before);
      end
      i += n;
    end

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- flist.f
+incdir+verif
rtl/simd_pkg.sv
rtl/simd_fifo.sv
rtl/simd_option_mem.sv
rtl/simd_lane_unit.sv
rtl/upstream_seq.sv
rtl/simd_wrapper.sv
verif/simd_wrapper_tb.sv
